// File: design/posit_consts.svh
// ****************************************
// Word and field sizes of the posit adder, 32-bit posits with es = 2
// Included by the package and by every design file that sizes a port
// ****************************************
`ifndef POSIT_CONSTS_SVH
`define POSIT_CONSTS_SVH

`define POSIT_N 32
`define POSIT_ES 2

// Signed scale holds regime * 4 + exponent
`define POSIT_SCALE_W 8

// Largest stored fraction, hidden bit not counted
`define POSIT_FRAC_W 27

// Extra bits kept below the fraction while adding
`define POSIT_GUARD_W 3

// Raw sum width: hidden bit, fraction and guard bits
`define ABITS (1 + `POSIT_FRAC_W + `POSIT_GUARD_W)

// Scale of maxpos, minpos is its negative
`define POSIT_MAX_SCALE (4 * (`POSIT_N - 2))

`endif

// File: design/posit_pkg.sv
// ****************************************
// Types shared by the posit decoder, raw adder and encoder
// ****************************************
`include "posit_consts.svh"

package posit_pkg;

    // Decoded operand, fraction without the hidden bit
    typedef struct packed {
        logic                               sgn;
        logic signed [`POSIT_SCALE_W-1:0]   scale;
        logic [`POSIT_FRAC_W-1:0]           fraction;
        logic                               inf;
        logic                               zero;
    } posit_value;

    // Normalized raw sum, hidden bit on top and guard bits below
    typedef struct packed {
        logic                               sgn;
        logic signed [`POSIT_SCALE_W-1:0]   scale;
        logic [`ABITS-1:0]                  fraction;
        logic                               inf;
        logic                               zero;
    } posit_sum;

    // Output cases of the encoder
    typedef enum logic [2:0] {
        ENC_ZERO,
        ENC_NAR,
        ENC_NORMAL,
        ENC_MAXPOS,
        ENC_MINPOS
    } enc_case_e;

endpackage

// File: design/posit_decode.sv
// ****************************************
// Unpacks a 32-bit posit into sign, scale and fraction
// One register stage, start travels with the data
// ****************************************
`timescale 1ns/100ps
`include "posit_consts.svh"

module posit_decode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic [`POSIT_N-1:0]     posit,
    output posit_pkg::posit_value   value,
    output logic                    value_start
);

    logic                       dec_zero;
    logic                       dec_nar;
    logic [`POSIT_N-1:0]        dec_abs;
    logic [`POSIT_N-2:0]        dec_body;
    logic                       regime_bit;
    logic [5:0]                 run_len;
    logic                       run_done;
    logic [5:0]                 reg_k;
    logic [`POSIT_N-2:0]        dec_rest;
    logic [`POSIT_ES-1:0]       dec_exp;
    posit_pkg::posit_value      dec_next;

    assign dec_zero = (posit == '0);
    assign dec_nar  = (posit == {1'b1, {(`POSIT_N-1){1'b0}}});

    // Negative words are decoded from their two's complement
    assign dec_abs    = posit[`POSIT_N-1] ? (~posit + 1'b1) : posit;
    assign dec_body   = dec_abs[`POSIT_N-2:0];
    assign regime_bit = dec_body[`POSIT_N-2];

    // Length of the regime run
    always_comb
    begin
        run_len  = '0;
        run_done = 1'b0;
        for (int i = `POSIT_N - 2; i >= 0; i--)
        begin
            if (!run_done && (dec_body[i] == regime_bit))
                run_len = run_len + 6'd1;
            else
                run_done = 1'b1;
        end
    end

    // Run of ones gives k = len - 1, run of zeros gives k = -len
    assign reg_k = regime_bit ? (run_len - 6'd1) : (6'd0 - run_len);

    // Drop the run and its terminating bit, exponent then fraction follow
    assign dec_rest = dec_body << (run_len + 6'd1);
    assign dec_exp  = dec_rest[`POSIT_N-2 -: `POSIT_ES];

    always_comb
    begin
        dec_next = '0;
        if (dec_nar)
        begin
            dec_next.inf = 1'b1;
        end
        else if (dec_zero)
        begin
            dec_next.zero = 1'b1;
        end
        else
        begin
            dec_next.sgn      = posit[`POSIT_N-1];
            dec_next.scale    = {reg_k, dec_exp};
            dec_next.fraction = dec_rest[`POSIT_N-2-`POSIT_ES -: `POSIT_FRAC_W];
        end
    end

    always_ff @(posedge clk)
    begin
        value <= dec_next;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            value_start <= 1'b0;
        else
            value_start <= start;
    end

endmodule

// File: design/posit_lod.sv
// ****************************************
// Leading-one detector for the raw fraction sum
// Gives the number of zeros above the first set bit
// ****************************************
`timescale 1ns/100ps
`include "posit_consts.svh"

module posit_lod (
    input  logic [`ABITS:0] bits,
    output logic [4:0]      pos
);

    // Scan upwards so the highest set bit is the one that sticks
    always_comb
    begin
        pos = 5'(`ABITS);
        for (int i = 0; i <= `ABITS; i++)
        begin
            if (bits[i])
            begin
                pos = 5'(`ABITS - i);
            end
        end
    end

endmodule

// File: design/posit_raw_add.sv
// ****************************************
// Adds two decoded posits: align, add or subtract, normalize
// Four register stages r0..r3, a new pair may enter every cycle
// ****************************************
`timescale 1ns/100ps
`include "posit_consts.svh"

module posit_raw_add (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  posit_pkg::posit_value   a,
    input  posit_pkg::posit_value   b,
    output posit_pkg::posit_sum     sum,
    output logic                    done,
    output logic                    truncated
);

    localparam int SCALE_X_W = `POSIT_SCALE_W + 2;
    localparam int SCALE_MAX = 2 ** (`POSIT_SCALE_W - 1) - 1;
    localparam int SCALE_MIN = -(2 ** (`POSIT_SCALE_W - 1));

    logic                           r0_start, r1_start, r2_start, r3_start;

    posit_pkg::posit_value          r0_a, r0_b;
    posit_pkg::posit_value          r0_hi, r0_low;
    logic                           r0_a_ge_b;
    logic                           r0_add;
    logic [`POSIT_SCALE_W-1:0]      r0_scale_diff;

    posit_pkg::posit_value          r1_hi, r1_low;
    logic                           r1_add;
    logic [`POSIT_SCALE_W-1:0]      r1_scale_diff;
    logic [2*`ABITS-1:0]            r1_low_shifted;
    logic                           r1_trunc;
    logic [`ABITS:0]                r1_hi_sig;
    logic [`ABITS:0]                r1_low_sig;
    logic [`ABITS:0]                r1_raw;

    logic [`ABITS:0]                r2_raw;
    logic                           r2_sgn;
    logic signed [`POSIT_SCALE_W-1:0] r2_scale;
    logic                           r2_inf;
    logic                           r2_zero;
    logic                           r2_trunc;
    logic [4:0]                     r2_lz;
    logic signed [SCALE_X_W-1:0]    r2_scale_x;
    logic [`ABITS:0]                r2_norm;
    posit_pkg::posit_sum            r2_sum;

    posit_pkg::posit_sum            r3_sum;
    logic                           r3_trunc;

    // Valid chain
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            r0_start <= 1'b0;
            r1_start <= 1'b0;
            r2_start <= 1'b0;
            r3_start <= 1'b0;
        end
        else
        begin
            r0_start <= start;
            r1_start <= r0_start;
            r2_start <= r1_start;
            r3_start <= r2_start;
        end
    end

    // r0: order by magnitude, zero always ends up as the low operand
    always_ff @(posedge clk)
    begin
        r0_a <= a;
        r0_b <= b;
    end

    assign r0_a_ge_b = r0_b.zero ||
                       (!r0_a.zero && ((r0_a.scale > r0_b.scale) ||
                                       ((r0_a.scale == r0_b.scale) &&
                                        (r0_a.fraction >= r0_b.fraction))));

    assign r0_hi         = r0_a_ge_b ? r0_a : r0_b;
    assign r0_low        = r0_a_ge_b ? r0_b : r0_a;
    assign r0_add        = r0_a.sgn ~^ r0_b.sgn;
    assign r0_scale_diff = r0_hi.scale - r0_low.scale;

    // r1: align the low significand and add
    always_ff @(posedge clk)
    begin
        r1_hi         <= r0_hi;
        r1_low        <= r0_low;
        r1_add        <= r0_add;
        r1_scale_diff <= r0_scale_diff;
    end

    assign r1_low_shifted = {~r1_low.zero, r1_low.fraction, {(`POSIT_GUARD_W + `ABITS){1'b0}}}
                            >> r1_scale_diff;
    assign r1_trunc       = |r1_low_shifted[`ABITS-1:0];

    assign r1_hi_sig  = {1'b0, ~r1_hi.zero, r1_hi.fraction, {`POSIT_GUARD_W{1'b0}}};
    assign r1_low_sig = {1'b0, r1_low_shifted[2*`ABITS-1:`ABITS]};

    // A truncated subtrahend leaves the exact difference just below the
    // raw one, so borrow one LSB and let sticky stand for the remainder
    assign r1_raw = r1_add ? (r1_hi_sig + r1_low_sig)
                           : (r1_hi_sig - r1_low_sig - {{`ABITS{1'b0}}, r1_trunc});

    // r2: normalize
    always_ff @(posedge clk)
    begin
        r2_raw   <= r1_raw;
        r2_sgn   <= r1_hi.sgn;
        r2_scale <= r1_hi.scale;
        r2_inf   <= r1_hi.inf | r1_low.inf;
        r2_zero  <= r1_hi.zero & r1_low.zero;
        r2_trunc <= r1_trunc;
    end

    posit_lod hidden_lod_i (
        .bits (r2_raw),
        .pos  (r2_lz)
    );

    // Carry out gives lz = 0 and scale + 1, cancellation lowers the scale
    assign r2_scale_x = {{2{r2_scale[`POSIT_SCALE_W-1]}}, r2_scale} + SCALE_X_W'(1)
                        - {{(SCALE_X_W-5){1'b0}}, r2_lz};

    // Hidden bit lands on bit ABITS, the lowest bit is dropped
    assign r2_norm = r2_raw << r2_lz;

    always_comb
    begin
        r2_sum.sgn      = r2_sgn;
        r2_sum.inf      = r2_inf;
        r2_sum.zero     = r2_zero;
        r2_sum.fraction = r2_norm[`ABITS:1];
        if (r2_scale_x > SCALE_MAX)
            r2_sum.scale = `POSIT_SCALE_W'(SCALE_MAX);
        else if (r2_scale_x < SCALE_MIN)
            r2_sum.scale = `POSIT_SCALE_W'(SCALE_MIN);
        else
            r2_sum.scale = r2_scale_x[`POSIT_SCALE_W-1:0];
    end

    // r3: output register
    always_ff @(posedge clk)
    begin
        r3_sum   <= r2_sum;
        r3_trunc <= r2_trunc | r2_norm[0];
    end

    assign sum       = r3_sum;
    assign done      = r3_start;
    assign truncated = r3_trunc;

endmodule

// File: design/posit_encode.sv
// ****************************************
// Rounds a raw sum to nearest even and packs it into a posit
// One register stage, saturates to maxpos and minpos
// ****************************************
`timescale 1ns/100ps
`include "posit_consts.svh"

module posit_encode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  posit_pkg::posit_sum     sum,
    input  logic                    sticky,
    output logic [`POSIT_N-1:0]     result,
    output logic                    done,
    output logic                    inexact
);

    localparam int VEC_W = 2 * (`ABITS + 1);

    posit_pkg::enc_case_e       enc_case;
    logic [`ABITS-2:0]          enc_frac;
    logic signed [5:0]          enc_k;
    logic [4:0]                 enc_shift;
    logic [1:0]                 enc_seed;
    logic signed [VEC_W-1:0]    enc_vec;
    logic signed [VEC_W-1:0]    enc_shifted;
    logic                       enc_rnd;
    logic                       enc_stk;
    logic                       enc_up;
    logic [`POSIT_N-1:0]        enc_rounded;
    logic [`POSIT_N-1:0]        enc_mag;
    logic                       enc_inexact;
    logic [`POSIT_N-1:0]        enc_result;

    // Fraction below the hidden bit, guard bits included
    assign enc_frac = sum.fraction[`ABITS-2:0];

    always_comb
    begin
        if (sum.inf)
            enc_case = posit_pkg::ENC_NAR;
        else if (sum.zero || (sum.fraction == '0))
            enc_case = posit_pkg::ENC_ZERO;
        else if (sum.scale >= `POSIT_MAX_SCALE)
            enc_case = posit_pkg::ENC_MAXPOS;
        else if (sum.scale < -`POSIT_MAX_SCALE)
            enc_case = posit_pkg::ENC_MINPOS;
        else
            enc_case = posit_pkg::ENC_NORMAL;
    end

    // Regime from a two-bit seed, arithmetic shift repeats its top bit
    // k >= 0 shifts by k, k < 0 by -k - 1 which is ~k
    assign enc_k     = 6'(sum.scale >>> 2);
    assign enc_shift = enc_k[5] ? ~enc_k[4:0] : enc_k[4:0];
    assign enc_seed  = enc_k[5] ? 2'b01 : 2'b10;
    assign enc_vec   = {enc_seed, sum.scale[`POSIT_ES-1:0], enc_frac,
                        {(VEC_W - `ABITS - 3){1'b0}}};
    assign enc_shifted = enc_vec >>> enc_shift;

    // Round to nearest, ties to even
    assign enc_rnd = enc_shifted[VEC_W-`POSIT_N];
    assign enc_stk = (|enc_shifted[VEC_W-`POSIT_N-1:0]) | sticky;
    assign enc_up  = enc_rnd & (enc_stk | enc_shifted[VEC_W-`POSIT_N+1]);
    assign enc_rounded = {1'b0, enc_shifted[VEC_W-1 -: `POSIT_N-1]} + `POSIT_N'(enc_up);

    always_comb
    begin
        case (enc_case)
            posit_pkg::ENC_NAR:
            begin
                enc_mag     = {1'b1, {(`POSIT_N-1){1'b0}}};
                enc_inexact = 1'b0;
            end
            posit_pkg::ENC_ZERO:
            begin
                enc_mag     = '0;
                enc_inexact = 1'b0;
            end
            posit_pkg::ENC_MAXPOS:
            begin
                enc_mag     = {1'b0, {(`POSIT_N-1){1'b1}}};
                enc_inexact = (sum.scale != `POSIT_MAX_SCALE) | (|enc_frac) | sticky;
            end
            posit_pkg::ENC_MINPOS:
            begin
                enc_mag     = `POSIT_N'(1);
                enc_inexact = 1'b1;
            end
            default:
            begin
                // Rounding past maxpos would reach NaR, hold at maxpos
                if (enc_rounded[`POSIT_N-1])
                    enc_mag = {1'b0, {(`POSIT_N-1){1'b1}}};
                else
                    enc_mag = enc_rounded;
                enc_inexact = enc_rnd | enc_stk;
            end
        endcase
    end

    // NaR is its own negative, so one negate covers every case
    assign enc_result = sum.sgn ? (~enc_mag + 1'b1) : enc_mag;

    always_ff @(posedge clk)
    begin
        result  <= enc_result;
        inexact <= enc_inexact;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            done <= 1'b0;
        else
            done <= start;
    end

endmodule

// File: design/posit_add_top.sv
// ****************************************
// Posit adder top: decode both operands, raw add, encode
// Result and done follow start by six cycles
// ****************************************
`timescale 1ns/100ps
`include "posit_consts.svh"

module posit_add_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic [`POSIT_N-1:0]     in1,
    input  logic [`POSIT_N-1:0]     in2,
    output logic [`POSIT_N-1:0]     result,
    output logic                    done,
    output logic                    inexact
);

    posit_pkg::posit_value  op_a;
    posit_pkg::posit_value  op_b;
    logic                   dec_start;
    posit_pkg::posit_sum    sum;
    logic                   add_start;
    logic                   truncated;

    posit_decode dec_a_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .posit       (in1),
        .value       (op_a),
        .value_start (dec_start)
    );

    // Both decoders run in step, one valid chain is enough
    posit_decode dec_b_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .posit       (in2),
        .value       (op_b),
        .value_start ()
    );

    posit_raw_add raw_add_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (dec_start),
        .a         (op_a),
        .b         (op_b),
        .sum       (sum),
        .done      (add_start),
        .truncated (truncated)
    );

    posit_encode enc_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (add_start),
        .sum     (sum),
        .sticky  (truncated),
        .result  (result),
        .done    (done),
        .inexact (inexact)
    );

endmodule

// File: tb/posit_add_assertions.sv
// ****************************************
// Protocol checks on the posit adder top, bound into posit_add_top
// ****************************************
`timescale 1ns/100ps
`include "posit_consts.svh"

module posit_add_assertions (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 start,
    input logic                 done,
    input logic                 inexact,
    input logic [`POSIT_N-1:0]  result
);

    done_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(done))
        else $error("done is unknown after reset");

    // Six register stages between start and done
    done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        $past(start, 6) |-> done)
        else $error("done missing six cycles after start");

    done_needs_start: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $past(start, 6))
        else $error("done without a start six cycles earlier");

    result_known: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !$isunknown({result, inexact}))
        else $error("result or inexact unknown with done");

endmodule

bind posit_add_top posit_add_assertions assertions_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .done    (done),
    .inexact (inexact),
    .result  (result)
);

// File: tb/posit_add_tb.sv
// ****************************************
// Testbench for the posit adder, directed cases then back-to-back random pairs
// Expected results come from an exact reference adder with RNE rounding
// ****************************************
`timescale 1ns/100ps
`include "posit_consts.svh"

module posit_add_tb;

    localparam int reset_cycles   = 10;
    localparam int idle_cycles    = 8;
    localparam int tail_cycles    = 4;
    localparam int n_directed     = 17;
    localparam int n_random       = 400;
    localparam int total_ops      = n_directed + n_random;
    localparam int timeout_cycles = reset_cycles + idle_cycles + tail_cycles
                                    + total_ops + 6 + 50;
    localparam logic [`POSIT_N-1:0] nar = {1'b1, {(`POSIT_N-1){1'b0}}};

    typedef struct packed {
        logic [`POSIT_N-1:0]    result;
        logic                   inexact;
    } expect_t;

    logic                   clk;
    logic                   rst_n;
    logic                   start;
    logic [`POSIT_N-1:0]    in1;
    logic [`POSIT_N-1:0]    in2;
    logic [`POSIT_N-1:0]    result;
    logic                   done;
    logic                   inexact;

    integer                 seed;
    int                     cyc = 0;
    int                     checked = 0;
    expect_t                exp_q[$];
    string                  name_q[$];
    int                     issue_q[$];

    posit_add_top dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .in1     (in1),
        .in2     (in2),
        .result  (result),
        .done    (done),
        .inexact (inexact)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "Stopping at the first error");
    endtask

    // Sign, scale and significand with the hidden bit at bit 27
    function automatic void decode_ref(
        input  logic [`POSIT_N-1:0] p,
        output logic                sgn,
        output int                  scale,
        output logic [127:0]        sig
    );
        logic [`POSIT_N-1:0]    mag;
        logic [63:0]            rest;
        int                     run;
        int                     k;
        sgn = p[31];
        mag = sgn ? -p : p;
        run = 1;
        for (int i = 29; i >= 0; i--)
        begin
            if ((run == 30 - i) && (mag[i] == mag[30]))
                run = run + 1;
        end
        k     = mag[30] ? run - 1 : -run;
        rest  = {mag[30:0], 33'd0} << (run + 1);
        scale = 4 * k + int'(rest[63:62]);
        sig   = {100'd0, 1'b1, rest[61:35]};
    endfunction

    // Value is mag * 2^lsb_scale, mag nonzero
    function automatic expect_t encode_ref(
        input logic         sgn,
        input int           lsb_scale,
        input logic [127:0] mag
    );
        logic [191:0]   pat;
        logic [30:0]    body;
        logic           rnd;
        logic           stk;
        int             p;
        int             s;
        int             k;
        int             e;
        int             len;
        expect_t        r;
        p = 0;
        for (int i = 0; i < 128; i++)
        begin
            if (mag[i])
                p = i;
        end
        s = lsb_scale + p;
        if (s >= 120)
        begin
            body      = '1;
            r.inexact = (s > 120) || (mag != (128'd1 << p));
        end
        else if (s < -120)
        begin
            body      = 31'd1;
            r.inexact = 1'b1;
        end
        else
        begin
            k   = s >>> 2;
            e   = s - 4 * k;
            pat = '0;
            len = 0;
            if (k >= 0)
            begin
                for (int i = 0; i <= k; i++)
                begin
                    pat[191 - len] = 1'b1;
                    len = len + 1;
                end
                len = len + 1;
            end
            else
            begin
                len = -k;
                pat[191 - len] = 1'b1;
                len = len + 1;
            end
            pat[191 - len] = e[1];
            pat[190 - len] = e[0];
            len = len + 2;
            for (int i = p - 1; i >= 0; i--)
            begin
                pat[191 - len] = mag[i];
                len = len + 1;
            end
            // Round to nearest even on the bit pattern
            body      = pat[191:161];
            rnd       = pat[160];
            stk       = |pat[159:0];
            body      = body + 31'(rnd & (stk | body[0]));
            r.inexact = rnd | stk;
        end
        r.result = sgn ? -{1'b0, body} : {1'b0, body};
        return r;
    endfunction

    function automatic expect_t posit_add_ref(
        input logic [`POSIT_N-1:0] a,
        input logic [`POSIT_N-1:0] b
    );
        logic           sgn_a;
        logic           sgn_b;
        logic           sgn;
        int             scale_a;
        int             scale_b;
        int             base;
        logic [127:0]   sig_a;
        logic [127:0]   sig_b;
        logic [127:0]   mag;
        expect_t        r;
        r.inexact = 1'b0;
        r.result  = '0;
        if ((a == nar) || (b == nar))
        begin
            r.result = nar;
            return r;
        end
        if ((a == '0) || (b == '0))
        begin
            r.result = (a == '0) ? b : a;
            return r;
        end
        decode_ref(a, sgn_a, scale_a, sig_a);
        decode_ref(b, sgn_b, scale_b, sig_b);
        // Far below the other operand only the sign of the small one matters
        if (scale_a - scale_b > 96)
        begin
            sig_a = sig_a << 96;
            sig_b = 128'd1;
            base  = scale_a - 123;
        end
        else if (scale_b - scale_a > 96)
        begin
            sig_b = sig_b << 96;
            sig_a = 128'd1;
            base  = scale_b - 123;
        end
        else if (scale_a >= scale_b)
        begin
            sig_a = sig_a << (scale_a - scale_b);
            base  = scale_b - 27;
        end
        else
        begin
            sig_b = sig_b << (scale_b - scale_a);
            base  = scale_a - 27;
        end
        if (sgn_a == sgn_b)
        begin
            mag = sig_a + sig_b;
            sgn = sgn_a;
        end
        else if (sig_a >= sig_b)
        begin
            mag = sig_a - sig_b;
            sgn = sgn_a;
        end
        else
        begin
            mag = sig_b - sig_a;
            sgn = sgn_b;
        end
        if (mag == '0)
            return r;
        return encode_ref(sgn, base, mag);
    endfunction

    task automatic check_posit(
        input string                name,
        input logic [`POSIT_N-1:0]  expected,
        input logic [`POSIT_N-1:0]  actual
    );
        if (actual !== expected)
        begin
            $display("Fail %s: result expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flag(
        input string    name,
        input logic     expected,
        input logic     actual
    );
        if (actual !== expected)
        begin
            $display("Fail %s: inexact expected %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic issue_op(
        input string                name,
        input logic [`POSIT_N-1:0]  a,
        input logic [`POSIT_N-1:0]  b
    );
        @(posedge clk);
        #0.5;
        start = 1'b1;
        in1   = a;
        in2   = b;
        exp_q.push_back(posit_add_ref(a, b));
        name_q.push_back(name);
        issue_q.push_back(cyc);
    endtask

    task automatic stop_issue();
        @(posedge clk);
        #0.5;
        start = 1'b0;
        in1   = '0;
        in2   = '0;
    endtask

    // Scale between -24 and +24 with a random fraction and sign
    task automatic make_random_operand(output logic [`POSIT_N-1:0] p);
        logic [31:0]    r_scale;
        logic [31:0]    r_frac;
        int             scale;
        expect_t        enc;
        r_scale = $random(seed);
        r_frac  = $random(seed);
        scale   = int'(r_scale[15:0] % 16'd49) - 24;
        enc     = encode_ref(r_scale[31], scale - 27, {100'd0, 1'b1, r_frac[26:0]});
        p       = enc.result;
    endtask

    task automatic run_directed();
        issue_op("zero_right", 32'h4A3C5D17, 32'h0);
        issue_op("zero_left", 32'h0, -32'h3C000000);
        issue_op("x_minus_x", 32'h4A3C5D17, -32'h4A3C5D17);
        issue_op("nar_left", nar, 32'h4A3C5D17);
        issue_op("nar_right", 32'h40000000, nar);
        issue_op("one_plus_one", 32'h40000000, 32'h40000000);
        issue_op("wide_gap", 32'h7F000000, 32'h00A00000);
        issue_op("wide_gap_neg", -32'h7F000000, -32'h00A00000);
        issue_op("gap_sticky", 32'h40000000, 32'h05123457);
        issue_op("gap_mixed", 32'h6ABCDEF1, 32'h1234567F);
        issue_op("near_max", 32'h7FFFFFF0, 32'h7FFFFF00);
        issue_op("cancel_lsb", 32'h4A3C5D17, -32'h4A3C5D16);
        issue_op("cancel_unit", 32'h40000000, -32'h3FFFFFFF);
        issue_op("cancel_mid", -32'h51234567, 32'h51234500);
        issue_op("maxpos_sat", 32'h7FFFFFFF, 32'h7FFFFFFF);
        issue_op("minpos_cancel", 32'h00000001, 32'hFFFFFFFF);
        issue_op("minpos_double", 32'h00000001, 32'h00000001);
    endtask

    task automatic run_random();
        logic [`POSIT_N-1:0] a;
        logic [`POSIT_N-1:0] b;
        for (int i = 0; i < n_random; i++)
        begin
            make_random_operand(a);
            make_random_operand(b);
            issue_op($sformatf("random_%0d", i), a, b);
        end
    endtask

    // Results are sampled mid-cycle, away from the clock edge
    always @(negedge clk)
    begin : compare_results
        expect_t    exp_val;
        string      name;
        int         issued;
        if (rst_n && (done !== 1'b0) && (done !== 1'b1))
        begin
            $display("done is unknown after reset");
            abort_run();
        end
        else if (rst_n && done)
        begin
            if (exp_q.size() == 0)
            begin
                $display("done went high with no operation in flight");
                abort_run();
            end
            else
            begin
                exp_val = exp_q.pop_front();
                name    = name_q.pop_front();
                issued  = issue_q.pop_front();
                if (cyc - issued != 6)
                begin
                    $display("Result of %s came %0d cycles after start, not 6",
                             name, cyc - issued);
                    abort_run();
                end
                check_posit(name, exp_val.result, result);
                check_flag(name, exp_val.inexact, inexact);
                checked = checked + 1;
            end
        end
    end

    always @(posedge clk)
    begin
        if (cyc > timeout_cycles)
        begin
            $display("Timeout after %0d cycles, results are missing", timeout_cycles);
            abort_run();
        end
    end

    initial
    begin
        rst_n = 1'b0;
        start = 1'b0;
        in1   = '0;
        in2   = '0;
        seed  = 32'h5536;
        repeat (reset_cycles)
            @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        // Quiet period, any done here is flagged by the compare process
        repeat (idle_cycles)
            @(posedge clk);
        run_directed();
        run_random();
        stop_issue();
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (tail_cycles)
            @(posedge clk);
        if (checked == total_ops)
        begin
            $display("Simulation passed");
            $finish;
        end
        else
        begin
            $display("Only %0d of %0d results were checked", checked, total_ops);
            abort_run();
        end
    end

endmodule

// File: filelist.f
+incdir+design
design/posit_pkg.sv
design/posit_decode.sv
design/posit_lod.sv
design/posit_raw_add.sv
design/posit_encode.sv
design/posit_add_top.sv
tb/posit_add_assertions.sv
tb/posit_add_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the posit adder testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module posit_add_tb -o posit_add_sim

status=0
./obj_dir/posit_add_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Simulation passed" sim.log; then
    echo "Run ended without a pass report"
    exit 1
fi
